// File: hdl/cnn_pkg.sv
package cnn_pkg;

	// 8-bit signed pixel or weight
	typedef logic signed [7:0] pixel_t;

	// holds a sum of nine 8x8 products with headroom
	typedef logic signed [19:0] acc_t;

	localparam int CONV_K = 3;                 // conv window side
	localparam int CONV_WIN = CONV_K * CONV_K; // elements per conv window
	localparam int POOL_K = 2;                 // pool window side and stride

	typedef enum logic {
		LAYER_CONV,
		LAYER_POOL
	} layer_op_e;

	typedef enum logic {
		ACT_NONE,
		ACT_RELU
	} act_e;

	// sequencer FSM
	typedef enum logic [1:0] {
		SEQ_IDLE,  // waiting for start_req
		SEQ_READ,  // streaming window elements
		SEQ_DRAIN, // waiting for the last results to be acked
		SEQ_DONE   // start_ack high until start_req drops
	} seq_state_e;

endpackage

// File: hdl/fm_ram.sv
`timescale 1ns/1ns

module fm_ram
	import cnn_pkg::*;
#(
	parameter int FM_SIZE = 6
) (
	input  logic clk,
	input  logic we_i,
	input  logic [$clog2(FM_SIZE*FM_SIZE)-1:0] waddr_i,
	input  pixel_t wdata_i,
	input  logic rd_en_i,
	input  logic [$clog2(FM_SIZE*FM_SIZE)-1:0] raddr_i,
	output pixel_t rd_data_o
);

	localparam int DEPTH = FM_SIZE * FM_SIZE;

	// row-major, one pixel per entry
	pixel_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
	end

	// registered read, data follows rd_en by one cycle
	always_ff @(posedge clk) begin
		if (rd_en_i) begin
			rd_data_o <= mem[raddr_i];
		end
	end

	// host loads and layer reads must never overlap on one entry
	a_no_rw_collision: assert property (@(posedge clk)
		!(we_i && rd_en_i && (waddr_i == raddr_i)));

endmodule

// File: hdl/window_sequencer.sv
`timescale 1ns/1ns

module window_sequencer
	import cnn_pkg::*;
#(
	parameter int FM_SIZE = 6
) (
	input  logic clk,
	input  logic rst,
	input  logic start_req_i,
	input  layer_op_e op_i,
	input  act_e act_i,
	output logic start_ack_o,
	output logic rd_en_o,
	output logic [$clog2(FM_SIZE*FM_SIZE)-1:0] rd_addr_o,
	output logic conv_pix_valid_o,
	output logic pool_pix_valid_o,
	output logic pix_first_o,
	output logic pix_last_o,
	output act_e act_o,
	input  logic slot_free_i,
	input  logic out_done_i
);

	localparam int ADDR_W = $clog2(FM_SIZE * FM_SIZE);
	localparam int POS_W = $clog2(FM_SIZE);
	localparam int RES_W = $clog2(FM_SIZE * FM_SIZE + 1);
	localparam int CONV_OUT = FM_SIZE - CONV_K + 1; // stride 1, no padding
	localparam int POOL_OUT = FM_SIZE / POOL_K;

	seq_state_e state;
	layer_op_e op_q;
	act_e act_q;
	logic [POS_W-1:0] out_r; // output position
	logic [POS_W-1:0] out_c;
	logic [POS_W-1:0] win_r; // element within the window
	logic [POS_W-1:0] win_c;
	logic [RES_W-1:0] done_cnt;
	logic [POS_W-1:0] win_max;
	logic [POS_W-1:0] out_max;
	logic [RES_W-1:0] res_total;
	logic [POS_W-1:0] row;
	logic [POS_W-1:0] col;
	logic win_first;
	logic win_last;
	logic pix_valid_q;
	logic pix_first_q;
	logic pix_last_q;

	always_comb begin
		if (op_q == LAYER_CONV) begin
			win_max = POS_W'(CONV_K - 1);
			out_max = POS_W'(CONV_OUT - 1);
			res_total = RES_W'(CONV_OUT * CONV_OUT);
			row = out_r + win_r;
			col = out_c + win_c;
		end else begin
			win_max = POS_W'(POOL_K - 1);
			out_max = POS_W'(POOL_OUT - 1);
			res_total = RES_W'(POOL_OUT * POOL_OUT);
			row = POS_W'(out_r * POOL_K) + win_r;
			col = POS_W'(out_c * POOL_K) + win_c;
		end
	end

	assign win_first = (win_r == '0) && (win_c == '0);
	assign win_last = (win_r == win_max) && (win_c == win_max);

	// hold back a window's last element until the output slot is empty
	assign rd_en_o = (state == SEQ_READ) && (!win_last || slot_free_i);
	assign rd_addr_o = ADDR_W'(row * FM_SIZE + col);
	assign start_ack_o = (state == SEQ_DONE);
	assign act_o = act_q;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= SEQ_IDLE;
			op_q <= LAYER_CONV;
			act_q <= ACT_NONE;
			out_r <= '0;
			out_c <= '0;
			win_r <= '0;
			win_c <= '0;
			done_cnt <= '0;
		end else begin
			if (out_done_i) begin
				done_cnt <= done_cnt + 1'b1;
			end
			case (state)
				SEQ_IDLE: begin
					if (start_req_i) begin
						op_q <= op_i;
						act_q <= act_i;
						done_cnt <= '0;
						state <= SEQ_READ;
					end
				end
				SEQ_READ: begin
					if (rd_en_o) begin
						if (win_c != win_max) begin
							win_c <= win_c + 1'b1;
						end else if (win_r != win_max) begin
							win_c <= '0;
							win_r <= win_r + 1'b1;
						end else begin
							win_c <= '0;
							win_r <= '0;
							if (out_c != out_max) begin
								out_c <= out_c + 1'b1;
							end else begin
								out_c <= '0;
								if (out_r != out_max) begin
									out_r <= out_r + 1'b1;
								end else begin
									out_r <= '0; // walk complete
									state <= SEQ_DRAIN;
								end
							end
						end
					end
				end
				SEQ_DRAIN: begin
					if (done_cnt == res_total) begin
						state <= SEQ_DONE;
					end
				end
				SEQ_DONE: begin
					if (!start_req_i) begin
						state <= SEQ_IDLE;
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	// align the stream flags with the registered ram data
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pix_valid_q <= 1'b0;
			pix_first_q <= 1'b0;
			pix_last_q <= 1'b0;
		end else begin
			pix_valid_q <= rd_en_o;
			pix_first_q <= rd_en_o && win_first;
			pix_last_q <= rd_en_o && win_last;
		end
	end

	assign conv_pix_valid_o = pix_valid_q && (op_q == LAYER_CONV);
	assign pool_pix_valid_o = pix_valid_q && (op_q == LAYER_POOL);
	assign pix_first_o = pix_first_q;
	assign pix_last_o = pix_last_q;

	// host holds the opcode while the request is pending
	a_op_stable: assert property (@(posedge clk) disable iff (!rst)
		(start_req_i && !start_ack_o) ##1 (start_req_i && !start_ack_o) |-> $stable(op_i));

endmodule

// File: hdl/conv_engine.sv
`timescale 1ns/1ns

module conv_engine
	import cnn_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic w_we_i,
	input  logic [3:0] w_addr_i,
	input  pixel_t w_data_i,
	input  logic pix_valid_i,
	input  logic pix_first_i,
	input  logic pix_last_i,
	input  pixel_t pix_i,
	output logic res_valid_o,
	output acc_t res_o
);

	pixel_t weights [CONV_WIN];
	logic [3:0] idx;     // weight for the next element
	logic [3:0] cur_idx;
	acc_t acc;
	acc_t prod;
	acc_t acc_next;

	always_ff @(posedge clk) begin
		if (w_we_i && (w_addr_i < CONV_WIN)) begin
			weights[w_addr_i] <= w_data_i;
		end
	end

	assign cur_idx = pix_first_i ? 4'd0 : idx; // restart at window start
	assign prod = acc_t'(pix_i) * acc_t'(weights[cur_idx]);
	assign acc_next = (pix_first_i ? acc_t'(0) : acc) + prod;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			idx <= '0;
			res_valid_o <= 1'b0;
		end else begin
			res_valid_o <= pix_valid_i && pix_last_i;
			if (pix_valid_i) begin
				idx <= pix_last_i ? 4'd0 : cur_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pix_valid_i) begin
			acc <= acc_next;
			if (pix_last_i) begin
				res_o <= acc_next;
			end
		end
	end

	// sequencer window length must match the kernel
	a_last_at_nine: assert property (@(posedge clk) disable iff (!rst)
		pix_valid_i && pix_last_i |-> cur_idx == CONV_WIN - 1);

endmodule

// File: hdl/max_pool_engine.sv
`timescale 1ns/1ns

module max_pool_engine
	import cnn_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic pix_valid_i,
	input  logic pix_first_i,
	input  logic pix_last_i,
	input  pixel_t pix_i,
	output logic res_valid_o,
	output acc_t res_o
);

	pixel_t max_q;
	pixel_t max_next;

	// signed compare, first element seeds the maximum
	always_comb begin
		if (pix_first_i || (pix_i > max_q)) begin
			max_next = pix_i;
		end else begin
			max_next = max_q;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			res_valid_o <= 1'b0;
		end else begin
			res_valid_o <= pix_valid_i && pix_last_i;
		end
	end

	always_ff @(posedge clk) begin
		if (pix_valid_i) begin
			max_q <= max_next;
			if (pix_last_i) begin
				res_o <= acc_t'(max_next); // sign extended
			end
		end
	end

endmodule

// File: hdl/result_writer.sv
`timescale 1ns/1ns

module result_writer
	import cnn_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic conv_valid_i,
	input  acc_t conv_res_i,
	input  logic pool_valid_i,
	input  acc_t pool_res_i,
	input  act_e act_i,
	output logic slot_free_o,
	output logic out_done_o,
	output logic out_req_o,
	output acc_t out_data_o,
	input  logic out_ack_i
);

	logic full;
	logic capture;
	acc_t sel;
	acc_t act_res;

	assign capture = conv_valid_i || pool_valid_i;
	assign sel = conv_valid_i ? conv_res_i : pool_res_i;
	assign act_res = ((act_i == ACT_RELU) && (sel < 0)) ? acc_t'(0) : sel;
	assign slot_free_o = !full;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			full <= 1'b0;
			out_req_o <= 1'b0;
			out_done_o <= 1'b0;
		end else begin
			out_done_o <= 1'b0;
			if (capture) begin
				full <= 1'b1;
				out_req_o <= 1'b1;
			end else if (out_req_o && out_ack_i) begin
				out_req_o <= 1'b0;
			end else if (full && !out_req_o && !out_ack_i) begin
				full <= 1'b0; // ack has fallen, handshake complete
				out_done_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			out_data_o <= act_res;
		end
	end

	// conv and pool never run together
	a_one_engine: assert property (@(posedge clk) disable iff (!rst)
		!(conv_valid_i && pool_valid_i));

	a_data_stable: assert property (@(posedge clk) disable iff (!rst)
		out_req_o && $past(out_req_o) |-> $stable(out_data_o));

	// sequencer stall must keep results out of a full slot
	a_no_overrun: assert property (@(posedge clk) disable iff (!rst)
		capture |-> !full);

endmodule

// File: hdl/cnn_layer_top.sv
`timescale 1ns/1ns

module cnn_layer_top
	import cnn_pkg::*;
#(
	parameter int FM_SIZE = 6
) (
	input  logic clk,
	input  logic rst,
	input  logic fm_we_i,
	input  logic [$clog2(FM_SIZE*FM_SIZE)-1:0] fm_addr_i,
	input  pixel_t fm_data_i,
	input  logic w_we_i,
	input  logic [3:0] w_addr_i,
	input  pixel_t w_data_i,
	input  logic start_req_i,
	input  layer_op_e op_i,
	input  act_e act_i,
	output logic start_ack_o,
	output logic out_req_o,
	output acc_t out_data_o,
	input  logic out_ack_i
);

	localparam int ADDR_W = $clog2(FM_SIZE * FM_SIZE);

	logic rd_en;
	logic [ADDR_W-1:0] rd_addr;
	pixel_t rd_data;
	logic conv_pix_valid;
	logic pool_pix_valid;
	logic pix_first;
	logic pix_last;
	act_e act;
	logic slot_free;
	logic out_done;
	logic conv_valid;
	acc_t conv_res;
	logic pool_valid;
	acc_t pool_res;

	fm_ram #(.FM_SIZE(FM_SIZE)) fm_ram_i (
		.clk(clk),
		.we_i(fm_we_i),
		.waddr_i(fm_addr_i),
		.wdata_i(fm_data_i),
		.rd_en_i(rd_en),
		.raddr_i(rd_addr),
		.rd_data_o(rd_data)
	);

	window_sequencer #(.FM_SIZE(FM_SIZE)) seq_i (
		.clk(clk),
		.rst(rst),
		.start_req_i(start_req_i),
		.op_i(op_i),
		.act_i(act_i),
		.start_ack_o(start_ack_o),
		.rd_en_o(rd_en),
		.rd_addr_o(rd_addr),
		.conv_pix_valid_o(conv_pix_valid),
		.pool_pix_valid_o(pool_pix_valid),
		.pix_first_o(pix_first),
		.pix_last_o(pix_last),
		.act_o(act),
		.slot_free_i(slot_free),
		.out_done_i(out_done)
	);

	// both engines watch the same pixel stream
	conv_engine conv_i (
		.clk(clk),
		.rst(rst),
		.w_we_i(w_we_i),
		.w_addr_i(w_addr_i),
		.w_data_i(w_data_i),
		.pix_valid_i(conv_pix_valid),
		.pix_first_i(pix_first),
		.pix_last_i(pix_last),
		.pix_i(rd_data),
		.res_valid_o(conv_valid),
		.res_o(conv_res)
	);

	max_pool_engine pool_i (
		.clk(clk),
		.rst(rst),
		.pix_valid_i(pool_pix_valid),
		.pix_first_i(pix_first),
		.pix_last_i(pix_last),
		.pix_i(rd_data),
		.res_valid_o(pool_valid),
		.res_o(pool_res)
	);

	result_writer writer_i (
		.clk(clk),
		.rst(rst),
		.conv_valid_i(conv_valid),
		.conv_res_i(conv_res),
		.pool_valid_i(pool_valid),
		.pool_res_i(pool_res),
		.act_i(act),
		.slot_free_o(slot_free),
		.out_done_o(out_done),
		.out_req_o(out_req_o),
		.out_data_o(out_data_o),
		.out_ack_i(out_ack_i)
	);

endmodule

// File: sim/cnn_layer_tb.sv
`timescale 1ns/1ns

module cnn_layer_tb
	import cnn_pkg::*;
();

	localparam int FM_SIZE = 6;
	localparam int FM_PIX = FM_SIZE * FM_SIZE;
	localparam int ADDR_W = $clog2(FM_PIX);
	localparam int CONV_OUT = FM_SIZE - CONV_K + 1;
	localparam int POOL_OUT = FM_SIZE / POOL_K;
	localparam int CLK_PERIOD = 8;
	localparam int MAX_ACK = 15;
	localparam int CONV_RUNS = 4;
	localparam int POOL_RUNS = 3;
	localparam int LOAD_CYCLES = 16 + FM_PIX + 1 + 2 * (CONV_WIN + 1) + 64;
	localparam int WATCHDOG_CYCLES =
		CONV_RUNS * CONV_OUT * CONV_OUT * (CONV_WIN + MAX_ACK + 8) +
		POOL_RUNS * POOL_OUT * POOL_OUT * (POOL_K * POOL_K + MAX_ACK + 8) + LOAD_CYCLES;

	logic clk;
	logic rst;
	logic fm_we_i;
	logic [ADDR_W-1:0] fm_addr_i;
	pixel_t fm_data_i;
	logic w_we_i;
	logic [3:0] w_addr_i;
	pixel_t w_data_i;
	logic start_req_i;
	layer_op_e op_i;
	act_e act_i;
	logic start_ack_o;
	logic out_req_o;
	acc_t out_data_o;
	logic out_ack_i;

	logic [31:0] lfsr_state;
	pixel_t fm_img [FM_PIX];
	pixel_t wgt [CONV_WIN];
	acc_t exp_mem [128]; // expected results of all layers, in order
	int exp_cnt;
	int exp_idx;         // next result to be accepted
	bit ack_rand;

	cnn_layer_top #(.FM_SIZE(FM_SIZE)) dut_i (
		.clk(clk),
		.rst(rst),
		.fm_we_i(fm_we_i),
		.fm_addr_i(fm_addr_i),
		.fm_data_i(fm_data_i),
		.w_we_i(w_we_i),
		.w_addr_i(w_addr_i),
		.w_data_i(w_data_i),
		.start_req_i(start_req_i),
		.op_i(op_i),
		.act_i(act_i),
		.start_ack_o(start_ack_o),
		.out_req_o(out_req_o),
		.out_data_o(out_data_o),
		.out_ack_i(out_ack_i)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic fail_now(input string line);
		$display("%s", line);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// reference conv sum for one output position
	function automatic int conv_sum(input int orow, input int ocol);
		int s;
		s = 0;
		for (int i = 0; i < CONV_K; i++) begin
			for (int j = 0; j < CONV_K; j++) begin
				s += int'(fm_img[(orow + i) * FM_SIZE + ocol + j]) * int'(wgt[i * CONV_K + j]);
			end
		end
		return s;
	endfunction

	function automatic bit conv_has_negative();
		bit neg;
		neg = 1'b0;
		for (int r = 0; r < CONV_OUT; r++) begin
			for (int c = 0; c < CONV_OUT; c++) begin
				if (conv_sum(r, c) < 0) neg = 1'b1;
			end
		end
		return neg;
	endfunction

	function automatic int pool_max(input int brow, input int bcol);
		int m;
		m = fm_img[brow * POOL_K * FM_SIZE + bcol * POOL_K];
		for (int i = 0; i < POOL_K; i++) begin
			for (int j = 0; j < POOL_K; j++) begin
				if (fm_img[(brow * POOL_K + i) * FM_SIZE + bcol * POOL_K + j] > m)
					m = fm_img[(brow * POOL_K + i) * FM_SIZE + bcol * POOL_K + j];
			end
		end
		return m;
	endfunction

	task automatic add_expect(input layer_op_e op, input act_e act);
		int v;
		int side;
		side = (op == LAYER_CONV) ? CONV_OUT : POOL_OUT;
		for (int r = 0; r < side; r++) begin
			for (int c = 0; c < side; c++) begin
				v = (op == LAYER_CONV) ? conv_sum(r, c) : pool_max(r, c);
				if (act == ACT_RELU && v < 0) v = 0; // relu clamps at zero
				exp_mem[exp_cnt] = acc_t'(v);
				exp_cnt++;
			end
		end
	endtask

	task automatic load_fm();
		for (int a = 0; a < FM_PIX; a++) begin
			@(negedge clk);
			fm_img[a] = pixel_t'(rand_bits(8));
			fm_we_i = 1'b1;
			fm_addr_i = ADDR_W'(a);
			fm_data_i = fm_img[a];
		end
		@(negedge clk);
		fm_we_i = 1'b0;
	endtask

	// redraw until the kernel gives at least one negative sum when asked
	task automatic load_weights(input bit need_negative);
		bit found;
		found = 1'b0;
		while (!found) begin
			for (int k = 0; k < CONV_WIN; k++) wgt[k] = pixel_t'(rand_bits(8));
			found = !need_negative || conv_has_negative();
		end
		for (int k = 0; k < CONV_WIN; k++) begin
			@(negedge clk);
			w_we_i = 1'b1;
			w_addr_i = 4'(k);
			w_data_i = wgt[k];
		end
		@(negedge clk);
		w_we_i = 1'b0;
	endtask

	task automatic run_layer(input layer_op_e op, input act_e act);
		add_expect(op, act);
		@(negedge clk);
		op_i = op;
		act_i = act;
		start_req_i = 1'b1;
		while (!start_ack_o) @(negedge clk);
		repeat (2) @(negedge clk); // request stays up, start_ack must hold
		start_req_i = 1'b0;
		while (start_ack_o) @(negedge clk);
	endtask

	// host side of the output handshake
	always begin
		@(negedge clk);
		if (out_req_o && !out_ack_i) begin
			if (ack_rand) repeat (rand_bits(4)) @(negedge clk);
			out_ack_i = 1'b1;
			while (out_req_o) @(negedge clk);
			out_ack_i = 1'b0;
			exp_idx = exp_idx + 1;
		end
	end

	a_result_value: assert property (@(posedge clk) disable iff (!rst)
		$rose(out_ack_i) |-> out_data_o == exp_mem[exp_idx])
		else fail_now($sformatf("Fail at %0t ns: result %0d is %0d, expected %0d", $time,
			$sampled(exp_idx), $sampled(out_data_o), exp_mem[$sampled(exp_idx)]));

	a_result_count: assert property (@(posedge clk) disable iff (!rst)
		$rose(out_ack_i) |-> exp_idx < exp_cnt)
		else fail_now($sformatf("Fail at %0t ns: more results than expected", $time));

	a_req_held: assert property (@(posedge clk) disable iff (!rst)
		out_req_o && !out_ack_i |=> out_req_o)
		else fail_now("out_req dropped before the ack arrived");

	a_data_stable: assert property (@(posedge clk) disable iff (!rst)
		out_req_o && $past(out_req_o) |-> $stable(out_data_o))
		else fail_now($sformatf("Fail at %0t ns: out_data changed while out_req high", $time));

	a_ack_last: assert property (@(posedge clk) disable iff (!rst)
		$rose(start_ack_o) |-> !out_req_o && !out_ack_i && exp_idx == exp_cnt)
		else fail_now("start_ack rose before every result was handed out");

	a_ack_held: assert property (@(posedge clk) disable iff (!rst)
		start_ack_o && start_req_i |=> start_ack_o)
		else fail_now("start_ack fell while start_req was still high");

	a_ack_release: assert property (@(posedge clk) disable iff (!rst)
		start_ack_o && !start_req_i |=> !start_ack_o)
		else fail_now("start_ack did not fall the cycle after start_req fell");

	a_reset_idle: assert property (@(posedge clk)
		$rose(rst) |-> !start_ack_o && !out_req_o)
		else fail_now("start_ack or out_req not low after reset");

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		fail_now("watchdog expired, a layer run never completed");
	end

	initial begin
		clk = 1'b0;
		rst = 1'b0;
		fm_we_i = 1'b0;
		fm_addr_i = '0;
		fm_data_i = '0;
		w_we_i = 1'b0;
		w_addr_i = '0;
		w_data_i = '0;
		start_req_i = 1'b0;
		op_i = LAYER_CONV;
		act_i = ACT_NONE;
		out_ack_i = 1'b0;
		lfsr_state = 32'h603e;
		exp_cnt = 0;
		exp_idx = 0;
		ack_rand = 1'b0;
		repeat (16) @(negedge clk);
		rst = 1'b1;

		load_fm();
		load_weights(1'b0);
		run_layer(LAYER_CONV, ACT_NONE);
		run_layer(LAYER_POOL, ACT_NONE);
		run_layer(LAYER_POOL, ACT_RELU);

		// same data again with a slow host
		ack_rand = 1'b1;
		run_layer(LAYER_CONV, ACT_NONE);
		run_layer(LAYER_POOL, ACT_NONE);

		load_weights(1'b1); // new kernel, some sums negative
		run_layer(LAYER_CONV, ACT_RELU);
		run_layer(LAYER_CONV, ACT_NONE);

		repeat (4) @(negedge clk);
		if (exp_idx == exp_cnt) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			fail_now($sformatf("Fail at %0t ns: %0d results accepted, %0d expected",
				$time, exp_idx, exp_cnt));
		end
	end

endmodule

// File: build.f
hdl/cnn_pkg.sv
hdl/fm_ram.sv
hdl/window_sequencer.sv
hdl/conv_engine.sv
hdl/max_pool_engine.sv
hdl/result_writer.sv
hdl/cnn_layer_top.sv
sim/cnn_layer_tb.sv
